/* verilog/rv_pkg.sv */
package rv_pkg;

    // address map
    localparam logic [63:0] ram_base = 64'h0000_0000_0000_0080; // reset pc, word 32
    localparam logic [63:0] key_base = 64'h0000_0000_1000_0000; // key input port
    localparam logic [63:0] art_base = 64'h0000_0000_1000_0008; // art output port

    // instruction memory geometry
    localparam int imem_words = 64;                  // isr at word 0, reset code at 32
    localparam int imem_aw    = $clog2(imem_words);  // word index width, pc[7:2]

    // fetch register content out of reset
    // not lui, not mret, not a custom word, so it runs as a nop
    localparam logic [31:0] nop_word = 32'h0000_0001;

    // opcodes and custom encodings
    localparam logic [6:0]  op_lui      = 7'b0110111;
    localparam logic [31:0] instr_mret  = 32'h0000_0000; // all zero word
    localparam logic [31:0] instr_load  = 32'hffff_ffff; // x5 <= key port
    localparam logic [31:0] instr_store = 32'hffff_ff7f; // art port <= x5, rd field 11110

    // mstatus bits
    localparam int mstatus_mie = 3; // machine interrupt enable

    // u-type view of an instruction word
    typedef struct packed {
        logic [19:0] imm20;  // upper immediate, bits 31:12
        logic [4:0]  rd;     // destination register
        logic [6:0]  opcode;
    } u_fmt_t;

    // one fetched word, decoded as a u-type field set or matched whole
    typedef union packed {
        u_fmt_t      u;
        logic [31:0] raw;  // compared against the custom words
    } instr_t;

    // core to peripheral request, registered in the core
    typedef struct packed {
        logic [63:0] address;
        logic [63:0] write_data;
        logic        write_enable;  // one cycle per store
        logic        read_enable;   // one cycle per load
    } bus_req_t;

    // art output word and its strobe
    typedef struct packed {
        logic        valid;  // single cycle pulse per write
        logic [63:0] data;
    } art_out_t;

endpackage

/* verilog/instr_mem.sv */
`timescale 1ns/1ps

// instruction store, loaded from outside, read asynchronously at pc
module instr_mem (
    input  logic                       clk,
    input  logic                       prog_we,    // load port write strobe
    input  logic [rv_pkg::imem_aw-1:0] prog_addr,  // word index
    input  rv_pkg::instr_t             prog_data,
    input  logic [63:0]                pc,
    output rv_pkg::instr_t             instr
);
    import rv_pkg::*;

    // word array, no reset so a loaded program survives reset
    instr_t mem [imem_words];

    // word index taken straight from the byte address
    logic [imem_aw-1:0] rd_index;

    assign rd_index = pc[imem_aw+1:2]; // drop byte offset bits

    // load port, only used while the core is held in reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // combinational read
    // core registers this into ir on the same edge, so no wait state
    assign instr = mem[rd_index];

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps

// two stage core: fetch into ir, execute ir the next cycle
module rv_core (
    input  logic             clk,
    input  logic             reset,       // async, active low
    input  rv_pkg::instr_t   instr,       // word at pc from instr_mem
    output logic [63:0]      pc,
    output rv_pkg::bus_req_t bus_req,
    input  logic [63:0]      read_data,   // valid the cycle after read_enable
    input  logic [3:0]       irq_vector,  // 1 means external irq pending
    output logic             irq_ack,
    output logic             heartbeat
);
    import rv_pkg::*;

    // architectural and pipeline state
    instr_t      ir;            // fetch register
    logic [63:0] regs [32];     // register file, only x5 is read back
    logic [63:0] mepc;          // return address for mret
    logic [63:0] mstatus;       // only mie is live
    logic        bubble;        // ir holds a wrong-path word this cycle
    logic        load_step;     // 0 issue read, 1 capture data

    // registered bus request fields
    logic [63:0] req_addr;
    logic [63:0] req_wdata;
    logic        req_we;
    logic        req_re;

    // decode
    logic        irq_take;
    logic        exec_valid;
    logic        do_lui;
    logic        do_mret;
    logic        do_load;
    logic        do_store;
    logic [63:0] lui_imm;

    // interrupt beats everything, then a pending bubble, then ir
    assign irq_take   = (irq_vector == 4'd1) && mstatus[mstatus_mie];
    assign exec_valid = !irq_take && !bubble;

    assign do_lui   = exec_valid && (ir.u.opcode == op_lui);
    assign do_mret  = exec_valid && (ir.raw == instr_mret);
    assign do_load  = exec_valid && (ir.raw == instr_load);
    assign do_store = exec_valid && (ir.raw == instr_store);
    // anything else falls through as a nop

    // upper immediate, sign extended from bit 31
    assign lui_imm = {{32{ir.u.imm20[19]}}, ir.u.imm20, 12'h000};

    // control state
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= nop_word;
            pc        <= ram_base;
            mstatus   <= 64'(1) << mstatus_mie; // interrupts enabled out of reset
            bubble    <= 1'b0;
            load_step <= 1'b0;
            req_we    <= 1'b0;
            req_re    <= 1'b0;
            irq_ack   <= 1'b0;
            heartbeat <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;
            ir        <= instr;     // fetch every cycle
            pc        <= pc + 64'd4; // default, overridden by redirects below
            irq_ack   <= 1'b0;
            req_we    <= 1'b0;      // enables are single cycle
            req_re    <= 1'b0;

            // every redirect flushes the word fetched alongside it
            bubble <= irq_take || do_mret || (do_load && !load_step);

            if (irq_take) begin
                pc                   <= 64'd0; // isr at word 0
                mstatus[mstatus_mie] <= 1'b0;
                irq_ack              <= 1'b1;
                load_step            <= 1'b0;  // interrupted load restarts from step 0
            end

            if (do_mret) begin
                pc                   <= mepc;
                mstatus[mstatus_mie] <= 1'b1;
            end

            if (do_load) begin
                if (!load_step) begin
                    req_re    <= 1'b1;
                    pc        <= pc - 64'd4; // refetch the load for step 1
                    load_step <= 1'b1;
                end else begin
                    load_step <= 1'b0;       // data captured below
                end
            end

            if (do_store) begin
                req_we <= 1'b1; // art port sees it next cycle
            end
        end
    end

    // payload, register file and mepc
    always_ff @(posedge clk) begin
        // mepc points at the first instruction not yet executed
        // during a bubble that is the word now being fetched at pc
        if (irq_take) begin
            mepc <= bubble ? pc : pc - 64'd4;
        end

        if (do_lui && (ir.u.rd != 5'd0)) begin // x0 stays zero
            regs[ir.u.rd] <= lui_imm;
        end

        if (do_load) begin
            if (load_step) begin
                regs[5] <= read_data;  // custom load always targets x5
            end else begin
                req_addr <= key_base;
            end
        end

        if (do_store) begin
            req_addr  <= art_base;
            req_wdata <= regs[5];
        end
    end

    assign bus_req = '{
        address:      req_addr,
        write_data:   req_wdata,
        write_enable: req_we,
        read_enable:  req_re
    };

endmodule

/* verilog/periph_bus.sv */
`timescale 1ns/1ps

// key input and art output ports on the core bus
module periph_bus (
    input  logic             clk,
    input  logic             reset,      // async, active low
    input  rv_pkg::bus_req_t bus_req,
    input  logic [63:0]      key_in,     // held stable by the outside world
    output logic [63:0]      read_data,  // answers one cycle after read_enable
    output rv_pkg::art_out_t art_out
);
    import rv_pkg::*;

    // address decode
    logic hit_key;
    logic hit_art;
    logic key_rd;
    logic art_wr;

    // art port registers
    logic        art_valid;
    logic [63:0] art_data;

    assign hit_key = (bus_req.address == key_base);
    assign hit_art = (bus_req.address == art_base);

    assign key_rd = bus_req.read_enable && hit_key;
    assign art_wr = bus_req.write_enable && hit_art; // other addresses dropped

    // read path, unmapped reads return zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            read_data <= 64'd0;
        end else if (key_rd) begin
            read_data <= key_in; // sample key at the request
        end else begin
            read_data <= 64'd0;
        end
    end

    // strobe, one cycle per write
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            art_valid <= 1'b0;
        end else begin
            art_valid <= art_wr;
        end
    end

    // data word, only meaningful with the strobe
    always_ff @(posedge clk) begin
        if (art_wr) begin
            art_data <= bus_req.write_data;
        end
    end

    assign art_out = '{valid: art_valid, data: art_data};

endmodule

/* verilog/irq_latch.sv */
`timescale 1ns/1ps

// stretches an external irq pulse into a held vector level
module irq_latch (
    input  logic       clk,
    input  logic       reset,       // async, active low
    input  logic       irq_req,     // one or more cycle pulse from outside
    input  logic       irq_ack,     // core took the interrupt
    output logic [3:0] irq_vector   // 1 while pending, else 0
);

    logic pending;

    // set by a request, cleared the cycle after ack
    // a request landing while pending merges with it
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pending <= 1'b0;
        end else if (irq_ack) begin
            pending <= 1'b0;  // ack wins over a simultaneous request
        end else if (irq_req) begin
            pending <= 1'b1;
        end
    end

    // single source, vector 1
    assign irq_vector = pending ? 4'd1 : 4'd0;

endmodule

/* verilog/soc_top.sv */
`timescale 1ns/1ps

// core, instruction store, peripherals and interrupt latch
module soc_top (
    input  logic                       clk,
    input  logic                       reset,      // async, active low
    input  logic                       prog_we,    // program load, only during reset
    input  logic [rv_pkg::imem_aw-1:0] prog_addr,
    input  rv_pkg::instr_t             prog_data,
    input  logic [63:0]                key_in,
    input  logic                       irq_req,
    output rv_pkg::art_out_t           art_out,
    output logic                       irq_ack,
    output logic                       heartbeat
);
    import rv_pkg::*;

    logic [63:0] pc;
    instr_t      instr;       // fetched word at pc
    bus_req_t    bus_req;
    logic [63:0] read_data;
    logic [3:0]  irq_vector;

    instr_mem imem_i (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .instr     (instr)
    );

    rv_core core_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .pc         (pc),
        .bus_req    (bus_req),
        .read_data  (read_data),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack),
        .heartbeat  (heartbeat)
    );

    periph_bus periph_i (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .key_in    (key_in),
        .read_data (read_data),
        .art_out   (art_out)
    );

    irq_latch irq_i (
        .clk        (clk),
        .reset      (reset),
        .irq_req    (irq_req),
        .irq_ack    (irq_ack),  // also exported for the testbench
        .irq_vector (irq_vector)
    );

endmodule

/* bench/soc_checker.sv */
`timescale 1ns/1ps

// protocol assertions on the core bus and interrupt handshake, bound into rv_core
module soc_checker (
    input logic             clk,
    input logic             reset,       // async, active low
    input rv_pkg::bus_req_t bus_req,
    input logic [3:0]       irq_vector,
    input logic             irq_ack
);

    int unsigned fail_count = 0; // failed assertions, summed into the verdict

    // one transfer direction per cycle
    bus_exclusive: assert property (
        @(posedge clk) disable iff (!reset)
        !(bus_req.read_enable && bus_req.write_enable)
    ) else begin
        fail_count++;
        $error("bus read and write enables high together");
    end

    // ack only while the latch still shows vector 1
    ack_with_vector: assert property (
        @(posedge clk) disable iff (!reset)
        irq_ack |-> (irq_vector == 4'd1)
    ) else begin
        fail_count++;
        $error("irq_ack high without vector 1 pending");
    end

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!reset)
        irq_ack |=> !irq_ack
    ) else begin
        fail_count++;
        $error("irq_ack held for two cycles");
    end

    // nop in ir, then the first fetched word executes, so two quiet samples
    quiet_after_reset: assert property (
        @(posedge clk)
        $rose(reset) |-> !(bus_req.read_enable || bus_req.write_enable) [*2]
    ) else begin
        fail_count++;
        $error("bus enable high before the first instruction executed");
    end

endmodule

/* bench/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb;
    import rv_pkg::*;

    localparam int clk_period   = 100; // ns
    localparam int reset_cycles = 16;
    localparam int main_words   = 16;  // main code at words 32..47
    localparam int irq_after    = 3;   // first irq follows this main output
    localparam int irq_count    = 2;   // second request arrives inside the isr

    logic               clk;
    logic               reset;
    logic               prog_we;
    logic [imem_aw-1:0] prog_addr;
    instr_t             prog_data;
    logic [63:0]        key_in;
    logic               irq_req;
    art_out_t           art_out;
    logic               irq_ack;
    logic               heartbeat;

    instr_t      prog [imem_words]; // image written through the load port
    art_out_t    expected_q [$];     // art pulses in order
    logic [19:0] imm_a;
    logic [19:0] imm_b;
    logic [19:0] imm_c;
    logic [19:0] imm_d;
    logic [19:0] imm_isr;
    int          expected_total = 0;
    int          art_count      = 0;
    int          ack_count      = 0;
    int          hb_edges       = 0; // rising edges since reset release
    int          value_errors   = 0;
    int          other_errors   = 0;

    soc_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .key_in    (key_in),
        .irq_req   (irq_req),
        .art_out   (art_out),
        .irq_ack   (irq_ack),
        .heartbeat (heartbeat)
    );

    bind rv_core soc_checker checker_i (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // lui value is imm << 12 sign extended from bit 31
    function automatic logic [63:0] upper_imm(input logic [19:0] imm);
        return 64'($signed({imm, 12'h000}));
    endfunction

    function automatic instr_t make_lui(input logic [4:0] rd, input logic [19:0] imm);
        instr_t w;
        w.u.imm20  = imm;
        w.u.rd     = rd;
        w.u.opcode = op_lui;
        return w;
    endfunction

    function automatic void fill_program();
        int i;
        for (i = 0; i < imem_words; i++) begin
            prog[i].raw = 32'h5a00_0013 | (32'(i) << 12); // addi-like filler that runs as a nop
        end
        prog[0]     = make_lui(5'd5, imm_isr); // isr
        prog[1].raw = instr_store;
        prog[2].raw = instr_mret;
        prog[32]    = make_lui(5'd5, imm_a);   // negative immediate
        prog[33].raw = instr_store;
        prog[34].raw = instr_load;             // x5 <= key
        prog[35].raw = instr_store;
        prog[37]    = make_lui(5'd5, imm_b);
        prog[39].raw = instr_store;            // irq goes out after this one
        prog[44]    = make_lui(5'd5, imm_c);   // 40..43 filler absorbs the irq
        prog[45].raw = instr_store;
        prog[46]    = make_lui(5'd7, imm_d);   // rd 7 leaves x5 untouched
        prog[47].raw = instr_store;
    endfunction

    // instruction level walk with its own x5 and mepc
    function automatic void build_expected(input logic [63:0] key, input int irq_at,
                                           input int irq_times);
        instr_t      word;
        art_out_t    item;
        logic [63:0] x5;
        int          idx;
        int          mepc_idx;
        int          main_stores;
        int          isr_left;
        bit          in_isr;
        int          step;
        x5          = '0;
        idx         = 32; // reset pc
        mepc_idx    = 0;
        main_stores = 0;
        isr_left    = 0;
        in_isr      = 1'b0;
        expected_q.delete();
        // stop when the main code runs off the top of memory
        for (step = 0; step < 4 * imem_words && idx < imem_words; step++) begin
            word = prog[idx];
            idx++;
            if (word.u.opcode == op_lui) begin
                if (word.u.rd == 5'd5) begin
                    x5 = upper_imm(word.u.imm20);
                end
            end else if (word.raw == instr_load) begin
                x5 = key;
            end else if (word.raw == instr_store) begin
                item.valid = 1'b1;
                item.data  = x5;
                expected_q.push_back(item);
                if (!in_isr) begin
                    main_stores++;
                    if (main_stores == irq_at && irq_times > 0) begin
                        mepc_idx = idx; // entry between main words
                        idx      = 0;
                        in_isr   = 1'b1;
                        isr_left = irq_times - 1;
                    end
                end
            end else if (word.raw == instr_mret) begin
                if (isr_left > 0) begin
                    idx = 0; // held request taken at mret with mepc unchanged
                    isr_left--;
                end else begin
                    idx    = mepc_idx;
                    in_isr = 1'b0;
                end
            end
        end
    endfunction

    task automatic write_memory();
        int i;
        for (i = 0; i < imem_words; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = imem_aw'(i);
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic check_art(input string name, input art_out_t expected, input art_out_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s at %0t: expected valid %b data %h, actual valid %b data %h",
                     name, $time, expected.valid, expected.data, actual.valid, actual.data);
        end
    endtask

    task automatic check_ack(input string name, input int expected, input int actual);
        if (actual != expected) begin
            value_errors++;
            $display("** Error %s at %0t: expected %0d, actual %0d", name, $time, expected, actual);
        end
    endtask

    task automatic check_heartbeat(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s at %0t: expected %b, actual %b", name, $time, expected, actual);
        end
    endtask

    // art strobes sampled on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (reset && art_out.valid) begin
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("art pulse with data %h after the expected sequence ended", art_out.data);
            end else begin
                check_art($sformatf("art pulse %0d", art_count), expected_q.pop_front(), art_out);
            end
            art_count++;
        end
    end

    always @(negedge clk) begin
        if (reset && irq_ack) begin
            ack_count++;
        end
    end

    // heartbeat starts at 0 and flips on every edge out of reset
    always @(posedge clk) begin
        if (reset) begin
            hb_edges++;
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            check_heartbeat("heartbeat", (hb_edges % 2) == 1, heartbeat);
        end
    end

    // irq pulses follow the observed art outputs
    initial begin : irq_stimulus
        int pulses;
        pulses = 0;
        wait (reset === 1'b1);
        while (pulses < irq_after) begin
            @(negedge clk);
            if (art_out.valid) begin
                pulses++;
            end
        end
        irq_req = 1'b1;
        @(negedge clk);
        irq_req = 1'b0;
        do begin
            @(negedge clk);
        end while (!irq_ack);
        @(negedge clk); // latch can set again once the ack cycle is over
        irq_req = 1'b1; // mie is clear here so it stays pending
        @(negedge clk);
        irq_req = 1'b0;
    end

    initial begin : watchdog
        #((imem_words + reset_cycles + main_words * 4 + 40) * clk_period);
        $display("timeout: only %0d of %0d art pulses seen", art_count, expected_total);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main_flow
        reset     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        key_in    = '0;
        irq_req   = 1'b0;
        void'($urandom(32'h900));
        key_in  = {$urandom(), $urandom()}; // stable for the whole run
        imm_a   = 20'($urandom()) | 20'h80000;
        imm_b   = 20'($urandom());
        imm_c   = 20'($urandom()) & 20'h7ffff;
        imm_d   = 20'($urandom());
        imm_isr = 20'($urandom());
        fill_program();
        build_expected(key_in, irq_after, irq_count);
        expected_total = expected_q.size();
        write_memory();                       // core held in reset meanwhile
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b1;
        wait (art_count >= expected_total);
        repeat (6) @(negedge clk);            // room for a stray pulse
        check_ack("irq ack count", irq_count, ack_count);
        $display("errors: %0d value, %0d protocol, %0d assertion", value_errors, other_errors,
                 dut_i.core_i.checker_i.fail_count);
        if (value_errors + other_errors + dut_i.core_i.checker_i.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
verilog/rv_pkg.sv
verilog/instr_mem.sv
verilog/rv_core.sv
verilog/periph_bus.sv
verilog/irq_latch.sv
verilog/soc_top.sv
bench/soc_checker.sv
bench/soc_tb.sv

/* Bender.yml */
package:
  name: rv_soc

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/instr_mem.sv
      - verilog/rv_core.sv
      - verilog/periph_bus.sv
      - verilog/irq_latch.sv
      - verilog/soc_top.sv
  - target: test
    files:
      - bench/soc_checker.sv
      - bench/soc_tb.sv
